// File: hdl/riscv_isa_pkg.sv
/*
  Instruction encodings for the RV32 integer subset run by the core.
  Fetch, decode and execute refer to these by scoped name.
*/
package riscv_isa_pkg;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // ADDI, ANDI, ORI, XORI
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  //////////////////////////////
  // Function codes
  //////////////////////////////
  localparam logic [2:0] F3_ADD = 3'b000;  // Also SUB with F7_SUB
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // Branch conditions
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  localparam logic [6:0] F7_SUB = 7'b0100000;

  // ADDI x0,x0,0
  // Loaded into every empty or killed pipeline slot
  localparam logic [31:0] NOP_INSN = 32'h0000_0013;

  //////////////////////////////
  // Register field positions
  //////////////////////////////
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int RD_LSB  = 7;

endpackage

// File: hdl/riscv_pipe_pkg.sv
/*
  Pipeline-wide sizes, reset PC, ALU and branch encodings, and the
  payload structs passed between fetch, decode and execute.
*/
package riscv_pipe_pkg;

  localparam int XLEN    = 32;  // Data width
  localparam int REG_CNT = 32;
  localparam int REG_AW  = 5;

  localparam logic [XLEN-1:0] PC_INIT    = 32'h200;
  localparam int unsigned     INSN_BYTES = 4;  // Fetch step of one full word

  typedef logic [REG_AW-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B  // LUI
  } alu_op_t;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_JAL
  } br_kind_t;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     insn;
  } if_id_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    alu_op_t         alu_op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] rs1_val;  // Branch compare sources
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] imm;
    reg_idx_t        dst;
    logic            we;
    br_kind_t        br;
  } id_ex_t;

endpackage

// File: hdl/riscv_wb_if.sv
/*
  Result of one instruction leaving execute. The registered copy feeds
  the register file and the bypass, a combinational copy the bypass only.
*/
interface riscv_wb_if;

  logic                              valid;
  logic                              we;
  riscv_pipe_pkg::reg_idx_t          dst;
  logic [riscv_pipe_pkg::XLEN-1:0]   r;
  logic [riscv_pipe_pkg::XLEN-1:0]   pc;

  modport producer (output valid, we, dst, r, pc);

  modport rf (input valid, we, dst, r);

  modport bypass (input valid, we, dst, r);

endinterface

// File: hdl/riscv_rf.sv
/*
  Integer register file, 32 x 32. Two asynchronous read ports,
  one write port fed by the write-back result.
*/
module riscv_rf
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  riscv_wb_if.rf                          wb,

  input  riscv_pipe_pkg::reg_idx_t        raddr1_i,
  input  riscv_pipe_pkg::reg_idx_t        raddr2_i,
  output logic [riscv_pipe_pkg::XLEN-1:0] rdata1_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] rdata2_o
);

  logic [riscv_pipe_pkg::XLEN-1:0] regs [riscv_pipe_pkg::REG_CNT];

  always_ff @(posedge clk_i)
  begin
    if (rst_n_i && wb.valid && wb.we && wb.dst != '0)  // x0 never written
      regs[wb.dst] <= wb.r;
  end

  assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// File: hdl/riscv_if.sv
/*
  Instruction fetch. Keeps one request outstanding on the instruction
  memory bus, steps the PC by one word per acknowledge, and follows
  redirects from the branch unit in execute.
*/
module riscv_if
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Instruction memory
  output logic                            imem_req_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] imem_adr_o,
  input  logic                            imem_ack_i,
  input  logic [31:0]                     imem_insn_i,

  // Redirect from execute
  input  logic                            bu_flush_i,
  input  logic [riscv_pipe_pkg::XLEN-1:0] bu_nxt_pc_i,

  output riscv_pipe_pkg::if_id_t          if_id_o
);

  logic [riscv_pipe_pkg::XLEN-1:0] adr_q;
  logic [riscv_pipe_pkg::XLEN-1:0] tgt_q;    // Redirect held for a stale fetch
  logic [riscv_pipe_pkg::XLEN-1:0] if_pc_q;
  logic [31:0]                     if_insn_q;
  logic                            req_q;
  logic                            kill_q;   // Outstanding fetch was flushed
  logic                            if_vld_q;
  logic                            done;
  logic                            keep;

  assign done = req_q & imem_ack_i;
  assign keep = done & ~kill_q & ~bu_flush_i;  // Data goes on to decode

  assign imem_req_o = req_q;
  assign imem_adr_o = adr_q;

  //////////////////////////////
  // Request and program counter
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      req_q  <= 1'b0;
      kill_q <= 1'b0;
      adr_q  <= riscv_pipe_pkg::PC_INIT;
    end
    else if (!req_q)
      req_q <= 1'b1;  // First request out of reset
    else if (done)
    begin
      kill_q <= 1'b0;
      if (bu_flush_i)
        adr_q <= bu_nxt_pc_i;
      else if (kill_q)
        adr_q <= tgt_q;
      else
        adr_q <= adr_q + riscv_pipe_pkg::INSN_BYTES;
    end
    else if (bu_flush_i)
      kill_q <= 1'b1;  // Address stays put until the ack
  end

  always_ff @(posedge clk_i)
  begin
    if (bu_flush_i)
      tgt_q <= bu_nxt_pc_i;
  end

  //////////////////////////////
  // Fetch to decode register
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      if_vld_q <= 1'b0;
    else
      if_vld_q <= keep;
  end

  always_ff @(posedge clk_i)
  begin
    if_pc_q   <= adr_q;
    if_insn_q <= keep ? imem_insn_i : riscv_isa_pkg::NOP_INSN;  // Bubbles carry a NOP
  end

  assign if_id_o = '{valid: if_vld_q, pc: if_pc_q, insn: if_insn_q};

endmodule

// File: hdl/riscv_id.sv
/*
  Instruction decode. Splits the instruction into ALU operation,
  immediate, destination and branch kind, reads both sources with
  bypass from execute and write-back, and registers the result.
*/
module riscv_id
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,

  input  riscv_pipe_pkg::if_id_t           if_id_i,
  input  logic                             bu_flush_i,

  // Register file read
  output riscv_pipe_pkg::reg_idx_t         rf_raddr1_o,
  output riscv_pipe_pkg::reg_idx_t         rf_raddr2_o,
  input  logic [riscv_pipe_pkg::XLEN-1:0]  rf_rdata1_i,
  input  logic [riscv_pipe_pkg::XLEN-1:0]  rf_rdata2_i,

  riscv_wb_if.bypass                       wb_byp,
  riscv_wb_if.bypass                       ex_byp,

  output riscv_pipe_pkg::id_ex_t           id_ex_o
);

  logic [31:0]                     insn;
  logic [6:0]                      opcode;
  logic [6:0]                      funct7;
  logic [2:0]                      funct3;
  riscv_pipe_pkg::reg_idx_t        rs1;
  riscv_pipe_pkg::reg_idx_t        rs2;
  riscv_pipe_pkg::reg_idx_t        rd;
  logic [riscv_pipe_pkg::XLEN-1:0] imm_i;
  logic [riscv_pipe_pkg::XLEN-1:0] imm_u;
  logic [riscv_pipe_pkg::XLEN-1:0] imm_b;
  logic [riscv_pipe_pkg::XLEN-1:0] imm_j;
  logic [riscv_pipe_pkg::XLEN-1:0] src1;
  logic [riscv_pipe_pkg::XLEN-1:0] src2;
  logic                            use_imm;
  logic                            vld_q;
  riscv_pipe_pkg::id_ex_t          id_ex_d;
  riscv_pipe_pkg::id_ex_t          id_ex_q;

  assign insn   = if_id_i.insn;
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rs1    = insn[riscv_isa_pkg::RS1_LSB +: riscv_pipe_pkg::REG_AW];
  assign rs2    = insn[riscv_isa_pkg::RS2_LSB +: riscv_pipe_pkg::REG_AW];
  assign rd     = insn[riscv_isa_pkg::RD_LSB +: riscv_pipe_pkg::REG_AW];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'h000};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  assign rf_raddr1_o = rs1;
  assign rf_raddr2_o = rs2;

  //////////////////////////////
  // Operand bypass
  //////////////////////////////
  // Youngest producer wins, x0 reads zero
  function automatic logic [riscv_pipe_pkg::XLEN-1:0] src_sel(
    input riscv_pipe_pkg::reg_idx_t        src,
    input logic [riscv_pipe_pkg::XLEN-1:0] rf_val
  );
    if (src == '0)
      return '0;
    else if (ex_byp.valid && ex_byp.we && ex_byp.dst == src)
      return ex_byp.r;
    else if (wb_byp.valid && wb_byp.we && wb_byp.dst == src)
      return wb_byp.r;  // Not yet in the register file
    else
      return rf_val;
  endfunction

  assign src1 = src_sel(rs1, rf_rdata1_i);
  assign src2 = src_sel(rs2, rf_rdata2_i);

  //////////////////////////////
  // Decode
  //////////////////////////////
  always_comb
  begin
    id_ex_d         = '0;
    use_imm         = 1'b0;
    id_ex_d.valid   = if_id_i.valid;
    id_ex_d.pc      = if_id_i.pc;
    id_ex_d.dst     = rd;
    id_ex_d.rs1_val = src1;
    id_ex_d.rs2_val = src2;
    id_ex_d.alu_op  = riscv_pipe_pkg::ALU_ADD;
    id_ex_d.br      = riscv_pipe_pkg::BR_NONE;

    case (opcode)
      riscv_isa_pkg::OPC_LUI:
      begin
        id_ex_d.alu_op = riscv_pipe_pkg::ALU_PASS_B;
        id_ex_d.imm    = imm_u;
        id_ex_d.we     = 1'b1;
        use_imm        = 1'b1;
      end
      riscv_isa_pkg::OPC_OP_IMM, riscv_isa_pkg::OPC_OP:
      begin
        use_imm     = (opcode == riscv_isa_pkg::OPC_OP_IMM);
        id_ex_d.imm = imm_i;
        id_ex_d.we  = 1'b1;
        case (funct3)
          riscv_isa_pkg::F3_ADD:
            id_ex_d.alu_op = (!use_imm && funct7 == riscv_isa_pkg::F7_SUB) ?
                             riscv_pipe_pkg::ALU_SUB : riscv_pipe_pkg::ALU_ADD;
          riscv_isa_pkg::F3_XOR: id_ex_d.alu_op = riscv_pipe_pkg::ALU_XOR;
          riscv_isa_pkg::F3_OR:  id_ex_d.alu_op = riscv_pipe_pkg::ALU_OR;
          riscv_isa_pkg::F3_AND: id_ex_d.alu_op = riscv_pipe_pkg::ALU_AND;
          riscv_isa_pkg::F3_SLT:
          begin
            id_ex_d.alu_op = riscv_pipe_pkg::ALU_SLT;
            id_ex_d.we     = ~use_imm;  // No SLTI
          end
          default: id_ex_d.we = 1'b0;
        endcase
      end
      riscv_isa_pkg::OPC_BRANCH:
      begin
        id_ex_d.imm = imm_b;
        if (funct3 == riscv_isa_pkg::F3_BEQ)
          id_ex_d.br = riscv_pipe_pkg::BR_BEQ;
        else if (funct3 == riscv_isa_pkg::F3_BNE)
          id_ex_d.br = riscv_pipe_pkg::BR_BNE;
      end
      riscv_isa_pkg::OPC_JAL:
      begin
        id_ex_d.imm = imm_j;
        id_ex_d.br  = riscv_pipe_pkg::BR_JAL;
        id_ex_d.we  = 1'b1;  // Link value comes from execute
      end
      default: ;  // Retires without a write
    endcase

    id_ex_d.we   = id_ex_d.we & (rd != '0);
    id_ex_d.op_a = src1;
    id_ex_d.op_b = use_imm ? id_ex_d.imm : src2;
  end

  //////////////////////////////
  // Decode to execute register
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      vld_q <= 1'b0;
    else
      vld_q <= if_id_i.valid & ~bu_flush_i;  // Killed by a taken branch
  end

  always_ff @(posedge clk_i)
  begin
    id_ex_q <= id_ex_d;
  end

  always_comb
  begin
    id_ex_o       = id_ex_q;
    id_ex_o.valid = vld_q;
  end

endmodule

// File: hdl/riscv_ex.sv
/*
  Execute stage. ALU and branch unit resolve the instruction from
  decode, a taken branch or JAL redirects fetch, and the result is
  registered into the write-back register that drives retire.
*/
module riscv_ex
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  input  riscv_pipe_pkg::id_ex_t          id_ex_i,

  // Branch unit
  output logic                            bu_flush_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] bu_nxt_pc_o,

  riscv_wb_if.producer                    ex_fwd,
  riscv_wb_if.producer                    wb,

  // Retire port
  output logic                            retire_valid_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] retire_pc_o,
  output logic                            retire_we_o,
  output riscv_pipe_pkg::reg_idx_t        retire_dst_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] retire_r_o
);

  logic [riscv_pipe_pkg::XLEN-1:0] alu_r;
  logic [riscv_pipe_pkg::XLEN-1:0] ex_r;
  logic [riscv_pipe_pkg::XLEN-1:0] wb_pc_q;
  logic [riscv_pipe_pkg::XLEN-1:0] wb_r_q;
  riscv_pipe_pkg::reg_idx_t        ex_dst;
  riscv_pipe_pkg::reg_idx_t        wb_dst_q;
  logic                            take;
  logic                            wb_vld_q;
  logic                            wb_we_q;

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb
  begin
    case (id_ex_i.alu_op)
      riscv_pipe_pkg::ALU_ADD:    alu_r = id_ex_i.op_a + id_ex_i.op_b;
      riscv_pipe_pkg::ALU_SUB:    alu_r = id_ex_i.op_a - id_ex_i.op_b;
      riscv_pipe_pkg::ALU_AND:    alu_r = id_ex_i.op_a & id_ex_i.op_b;
      riscv_pipe_pkg::ALU_OR:     alu_r = id_ex_i.op_a | id_ex_i.op_b;
      riscv_pipe_pkg::ALU_XOR:    alu_r = id_ex_i.op_a ^ id_ex_i.op_b;
      riscv_pipe_pkg::ALU_SLT:
        alu_r = {{(riscv_pipe_pkg::XLEN-1){1'b0}},
                 $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
      riscv_pipe_pkg::ALU_PASS_B: alu_r = id_ex_i.op_b;
      default:                    alu_r = '0;
    endcase
  end

  // JAL writes the return address
  assign ex_r = (id_ex_i.br == riscv_pipe_pkg::BR_JAL) ?
                id_ex_i.pc + riscv_pipe_pkg::INSN_BYTES : alu_r;

  // A killed slot behaves as the NOP and targets x0
  assign ex_dst = id_ex_i.valid ? id_ex_i.dst :
                  riscv_isa_pkg::NOP_INSN[riscv_isa_pkg::RD_LSB +: riscv_pipe_pkg::REG_AW];

  //////////////////////////////
  // Branch unit
  //////////////////////////////
  always_comb
  begin
    case (id_ex_i.br)
      riscv_pipe_pkg::BR_BEQ: take = (id_ex_i.rs1_val == id_ex_i.rs2_val);
      riscv_pipe_pkg::BR_BNE: take = (id_ex_i.rs1_val != id_ex_i.rs2_val);
      riscv_pipe_pkg::BR_JAL: take = 1'b1;
      default:                take = 1'b0;
    endcase
  end

  assign bu_flush_o  = id_ex_i.valid & take;  // Predicted not taken, so redirect
  assign bu_nxt_pc_o = id_ex_i.pc + id_ex_i.imm;

  // Result still in execute, for the first bypass level
  assign ex_fwd.valid = id_ex_i.valid;
  assign ex_fwd.we    = id_ex_i.we;
  assign ex_fwd.dst   = ex_dst;
  assign ex_fwd.r     = ex_r;
  assign ex_fwd.pc    = id_ex_i.pc;

  //////////////////////////////
  // Write-back register
  //////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wb_vld_q <= 1'b0;
      wb_we_q  <= 1'b0;
    end
    else
    begin
      wb_vld_q <= id_ex_i.valid;
      wb_we_q  <= id_ex_i.valid & id_ex_i.we;
    end
  end

  always_ff @(posedge clk_i)
  begin
    wb_pc_q  <= id_ex_i.pc;
    wb_dst_q <= ex_dst;
    wb_r_q   <= ex_r;
  end

  assign wb.valid = wb_vld_q;
  assign wb.we    = wb_we_q;
  assign wb.dst   = wb_dst_q;
  assign wb.r     = wb_r_q;
  assign wb.pc    = wb_pc_q;

  assign retire_valid_o = wb.valid;
  assign retire_pc_o    = wb.pc;
  assign retire_we_o    = wb.we;
  assign retire_dst_o   = wb.dst;
  assign retire_r_o     = wb.r;

endmodule

// File: hdl/riscv_core.sv
/*
  Small in-order RV32 integer core. Fetch, decode, execute and the
  register file, with an instruction memory request/acknowledge bus
  and a retire port showing every completed instruction.
*/
module riscv_core
(
  input  logic                            clk_i,
  input  logic                            rst_n_i,

  // Instruction memory bus
  output logic                            imem_req_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] imem_adr_o,
  input  logic                            imem_ack_i,
  input  logic [31:0]                     imem_insn_i,

  // Retire port
  output logic                            retire_valid_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] retire_pc_o,
  output logic                            retire_we_o,
  output riscv_pipe_pkg::reg_idx_t        retire_dst_o,
  output logic [riscv_pipe_pkg::XLEN-1:0] retire_r_o
);

  riscv_pipe_pkg::if_id_t          if_id;
  riscv_pipe_pkg::id_ex_t          id_ex;
  logic                            bu_flush;
  logic [riscv_pipe_pkg::XLEN-1:0] bu_nxt_pc;
  riscv_pipe_pkg::reg_idx_t        rf_raddr1;
  riscv_pipe_pkg::reg_idx_t        rf_raddr2;
  logic [riscv_pipe_pkg::XLEN-1:0] rf_rdata1;
  logic [riscv_pipe_pkg::XLEN-1:0] rf_rdata2;

  riscv_wb_if wb_bus ();      // Registered result
  riscv_wb_if ex_fwd_bus ();  // Result in execute

  //////////////////////////////
  // Pipeline
  //////////////////////////////
  riscv_if u_if (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .imem_req_o  ( imem_req_o  ),
    .imem_adr_o  ( imem_adr_o  ),
    .imem_ack_i  ( imem_ack_i  ),
    .imem_insn_i ( imem_insn_i ),
    .bu_flush_i  ( bu_flush    ),
    .bu_nxt_pc_i ( bu_nxt_pc   ),
    .if_id_o     ( if_id       )
  );

  riscv_id u_id (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .if_id_i     ( if_id       ),
    .bu_flush_i  ( bu_flush    ),
    .rf_raddr1_o ( rf_raddr1   ),
    .rf_raddr2_o ( rf_raddr2   ),
    .rf_rdata1_i ( rf_rdata1   ),
    .rf_rdata2_i ( rf_rdata2   ),
    .wb_byp      ( wb_bus      ),
    .ex_byp      ( ex_fwd_bus  ),
    .id_ex_o     ( id_ex       )
  );

  riscv_ex u_ex (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .id_ex_i        ( id_ex          ),
    .bu_flush_o     ( bu_flush       ),
    .bu_nxt_pc_o    ( bu_nxt_pc      ),
    .ex_fwd         ( ex_fwd_bus     ),
    .wb             ( wb_bus         ),
    .retire_valid_o ( retire_valid_o ),
    .retire_pc_o    ( retire_pc_o    ),
    .retire_we_o    ( retire_we_o    ),
    .retire_dst_o   ( retire_dst_o   ),
    .retire_r_o     ( retire_r_o     )
  );

  riscv_rf u_rf (
    .clk_i    ( clk_i     ),
    .rst_n_i  ( rst_n_i   ),
    .wb       ( wb_bus    ),
    .raddr1_i ( rf_raddr1 ),
    .raddr2_i ( rf_raddr2 ),
    .rdata1_o ( rf_rdata1 ),
    .rdata2_o ( rf_rdata2 )
  );

endmodule

// File: verif/riscv_tb_clk.sv
/*
  Clock and reset for the core testbench. Period of 10, reset held
  low for the first 10 cycles and released on a falling edge.
*/
module riscv_tb_clk
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial
  begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // Away from the sampling edge
  end

endmodule

// File: verif/riscv_core_chk.sv
/*
  Checker bound to riscv_core. Watches the instruction bus and the
  retire port against the expected result of each program address.
*/
module riscv_core_chk
(
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            req_i,
  input logic [riscv_pipe_pkg::XLEN-1:0] adr_i,
  input logic                            ack_i,
  input logic                            ret_valid_i,
  input logic [riscv_pipe_pkg::XLEN-1:0] ret_pc_i,
  input logic                            ret_we_i,
  input logic [4:0]                      ret_dst_i,
  input logic [riscv_pipe_pkg::XLEN-1:0] ret_r_i
);

  typedef struct packed {
    logic        known;  // Address is on the executed path
    logic [31:0] succ;   // Next retired pc
    logic        we;
    logic [4:0]  dst;
    logic [31:0] r;
  } ent_t;

  //////////////////////////////
  // Program table
  //////////////////////////////
  function automatic ent_t lookup(input logic [31:0] pc);
    case (pc)
      32'h200: return '{1'b1, 32'h204, 1'b1, 5'd1,  32'h0000_0005};
      32'h204: return '{1'b1, 32'h208, 1'b1, 5'd2,  32'h0000_0003};
      32'h208: return '{1'b1, 32'h20c, 1'b1, 5'd3,  32'hffff_ffff};
      32'h20c: return '{1'b1, 32'h210, 1'b1, 5'd4,  32'h0000_00f0};
      32'h210: return '{1'b1, 32'h214, 1'b1, 5'd5,  32'h0000_0055};
      32'h214: return '{1'b1, 32'h218, 1'b1, 5'd7,  32'h0000_005a};  // 5 + 0x55
      32'h218: return '{1'b1, 32'h21c, 1'b1, 5'd8,  32'h0000_0057};  // 0x5a - 3
      32'h21c: return '{1'b1, 32'h220, 1'b1, 5'd9,  32'h0000_0052};
      32'h220: return '{1'b1, 32'h224, 1'b1, 5'd10, 32'h0000_0057};
      32'h224: return '{1'b1, 32'h228, 1'b1, 5'd11, 32'h0000_0005};
      32'h228: return '{1'b1, 32'h22c, 1'b1, 5'd12, 32'h0000_0001};  // 5 < 0x57
      32'h22c: return '{1'b1, 32'h230, 1'b1, 5'd13, 32'h1234_5000};
      32'h230: return '{1'b1, 32'h238, 1'b0, 5'd0,  32'h0};  // BNE taken
      32'h238: return '{1'b1, 32'h23c, 1'b0, 5'd0,  32'h0};  // BEQ falls through
      32'h23c: return '{1'b1, 32'h240, 1'b1, 5'd15, 32'h0000_0123};
      32'h240: return '{1'b1, 32'h248, 1'b1, 5'd6,  32'h0000_0244};  // Link value
      32'h248: return '{1'b1, 32'h248, 1'b0, 5'd0,  32'h0};
      default: return '0;
    endcase
  endfunction

  ent_t        ret_ent;
  ent_t        last_ent;
  logic [31:0] exp_ret_pc;
  logic [31:0] exp_adr;
  logic [31:0] last_pc_q;
  logic [31:0] last_adr_q;  // Last acknowledged address
  logic [31:0] prev_adr_q;
  logic [31:0] tgt_q;
  logic        seen_q;
  logic        pend_q;      // Redirect not yet seen on the bus
  logic        ack_q;
  logic        redir_now;
  int          err_cnt = 0;

  assign ret_ent    = lookup(ret_pc_i);
  assign last_ent   = lookup(last_pc_q);
  assign exp_ret_pc = seen_q ? last_ent.succ : riscv_pipe_pkg::PC_INIT;
  assign redir_now  = ret_valid_i && ret_ent.known && ret_ent.succ != ret_pc_i + 32'd4;
  assign exp_adr    = redir_now ? ret_ent.succ : pend_q ? tgt_q : last_adr_q + 32'd4;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      seen_q <= 1'b0;
      pend_q <= 1'b0;
      ack_q  <= 1'b0;
    end
    else
    begin
      ack_q <= req_i & ack_i;
      if (ret_valid_i)
      begin
        seen_q    <= 1'b1;
        last_pc_q <= ret_pc_i;
      end
      if (ack_q && req_i)
        pend_q <= 1'b0;  // New request has gone out
      else if (redir_now)
        pend_q <= 1'b1;
    end
    prev_adr_q <= adr_i;
    if (req_i && ack_i)
      last_adr_q <= adr_i;
    if (redir_now)
      tgt_q <= ret_ent.succ;
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////
  a_rst_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !req_i && !ret_valid_i)
    else begin err_cnt++; $error("Request or retire active during reset"); end

  a_first_req: assert property (@(posedge clk_i)
    $rose(rst_n_i) |=> req_i && adr_i == riscv_pipe_pkg::PC_INIT)
    else begin err_cnt++; $error("FAILED imem_adr_o: got %h expected %h (first request)",
                                 $sampled(adr_i), riscv_pipe_pkg::PC_INIT); end

  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && !ack_i |=> req_i && adr_i == prev_adr_q)
    else begin err_cnt++; $error("FAILED imem_req_o/imem_adr_o: got %h/%h expected 1/%h",
                                 $sampled(req_i), $sampled(adr_i), $sampled(prev_adr_q)); end

  a_next_adr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && ack_i |=> adr_i == exp_adr)
    else begin err_cnt++; $error("FAILED imem_adr_o: got %h expected %h",
                                 $sampled(adr_i), $sampled(exp_adr)); end

  a_ret_path: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_valid_i |-> ret_ent.known)
    else begin err_cnt++; $error("Retired pc %h is off the program path",
                                 $sampled(ret_pc_i)); end

  a_ret_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_valid_i |-> ret_pc_i == exp_ret_pc)
    else begin err_cnt++; $error("FAILED retire_pc_o: got %h expected %h",
                                 $sampled(ret_pc_i), $sampled(exp_ret_pc)); end

  a_ret_we: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_valid_i |-> ret_we_i == ret_ent.we)
    else begin err_cnt++; $error("FAILED retire_we_o: got %h expected %h",
                                 $sampled(ret_we_i), $sampled(ret_ent.we)); end

  a_ret_dst: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_valid_i && ret_we_i |-> ret_dst_i != '0 && ret_dst_i == ret_ent.dst)
    else begin err_cnt++; $error("FAILED retire_dst_o: got %h expected %h",
                                 $sampled(ret_dst_i), $sampled(ret_ent.dst)); end

  a_ret_r: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_valid_i && ret_we_i |-> ret_r_i == ret_ent.r)
    else begin err_cnt++; $error("FAILED retire_r_o: got %h expected %h",
                                 $sampled(ret_r_i), $sampled(ret_ent.r)); end

endmodule

// File: verif/riscv_core_tb.sv
/*
  Testbench for the core. An instruction memory with a random
  acknowledge delay serves a fixed program; the bound checker does
  the checking and this module waits for the final loop and reports.
*/
module riscv_core_tb;

  localparam int          PROG_WORDS  = 19;
  localparam logic [31:0] LOOP_PC     = riscv_pipe_pkg::PC_INIT + 32'h48;
  localparam int          RST_TIMEOUT = 50;
  localparam int          RUN_TIMEOUT = 600;

  logic                            clk;
  logic                            rst_n;
  logic                            imem_req;
  logic [riscv_pipe_pkg::XLEN-1:0] imem_adr;
  logic                            imem_ack  = 1'b0;
  logic [31:0]                     imem_insn = '0;
  logic                            retire_valid;
  logic [riscv_pipe_pkg::XLEN-1:0] retire_pc;
  logic                            retire_we;
  logic [4:0]                      retire_dst;
  logic [riscv_pipe_pkg::XLEN-1:0] retire_r;
  logic [31:0]                     prog [PROG_WORDS];
  integer                          seed = 32'h479e;
  int                              delay = 0;
  logic                            busy = 1'b0;  // Request seen, ack not yet given

  riscv_tb_clk u_clk (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  riscv_core u_dut (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .imem_req_o     ( imem_req     ),
    .imem_adr_o     ( imem_adr     ),
    .imem_ack_i     ( imem_ack     ),
    .imem_insn_i    ( imem_insn    ),
    .retire_valid_o ( retire_valid ),
    .retire_pc_o    ( retire_pc    ),
    .retire_we_o    ( retire_we    ),
    .retire_dst_o   ( retire_dst   ),
    .retire_r_o     ( retire_r     )
  );

  bind riscv_core riscv_core_chk u_chk (
    .clk_i       ( clk_i          ),
    .rst_n_i     ( rst_n_i        ),
    .req_i       ( imem_req_o     ),
    .adr_i       ( imem_adr_o     ),
    .ack_i       ( imem_ack_i     ),
    .ret_valid_i ( retire_valid_o ),
    .ret_pc_i    ( retire_pc_o    ),
    .ret_we_i    ( retire_we_o    ),
    .ret_dst_i   ( retire_dst_o   ),
    .ret_r_i     ( retire_r_o     )
  );

  //////////////////////////////
  // Program image at PC_INIT
  //////////////////////////////
  initial
  begin
    prog[0]  = 32'h0050_0093;  // addi x1, x0, 5
    prog[1]  = 32'h0030_0113;  // addi x2, x0, 3
    prog[2]  = 32'hfff0_0193;  // addi x3, x0, -1
    prog[3]  = 32'h0f00_0213;  // addi x4, x0, 0xf0
    prog[4]  = 32'h0550_0293;  // addi x5, x0, 0x55
    prog[5]  = 32'h0050_83b3;  // add  x7, x1, x5
    prog[6]  = 32'h4023_8433;  // sub  x8, x7, x2
    prog[7]  = 32'h0074_74b3;  // and  x9, x8, x7
    prog[8]  = 32'h0084_e533;  // or   x10, x9, x8
    prog[9]  = 32'h0095_45b3;  // xor  x11, x10, x9
    prog[10] = 32'h00a5_a633;  // slt  x12, x11, x10
    prog[11] = 32'h1234_56b7;  // lui  x13, 0x12345
    prog[12] = 32'h0020_9463;  // bne  x1, x2, +8
    prog[13] = 32'h7ff0_0713;  // addi x14, x0, 0x7ff (skipped)
    prog[14] = 32'h0020_8463;  // beq  x1, x2, +8
    prog[15] = 32'h1230_0793;  // addi x15, x0, 0x123
    prog[16] = 32'h0080_036f;  // jal  x6, +8
    prog[17] = 32'h0010_0813;  // addi x16, x0, 1 (skipped)
    prog[18] = 32'h0000_006f;  // jal  x0, 0
  end

  function automatic logic [31:0] read_word(input logic [31:0] adr);
    logic [31:0] idx;
    idx = (adr - riscv_pipe_pkg::PC_INIT) >> 2;
    if (adr >= riscv_pipe_pkg::PC_INIT && idx < PROG_WORDS)
      return prog[idx];
    return adr ^ 32'ha5a5_a5a5;  // Outside the program
  endfunction

  // Instruction memory, 0 to 3 cycles per request
  always @(negedge clk)
  begin
    imem_ack  = 1'b0;
    imem_insn = '0;
    if (rst_n && imem_req)
    begin
      if (!busy)
      begin
        busy  = 1'b1;
        delay = $unsigned($random(seed)) % 4;
      end
      if (delay == 0)
      begin
        imem_ack  = 1'b1;
        imem_insn = read_word(imem_adr);
        busy      = 1'b0;
      end
      else
        delay = delay - 1;
    end
    else
      busy = 1'b0;
  end

  //////////////////////////////
  // Run control and report
  //////////////////////////////
  initial
  begin
    int cyc;
    int loop_hits;
    int timeouts;
    int errors;
    cyc       = 0;
    loop_hits = 0;
    timeouts  = 0;
    while (!rst_n && cyc < RST_TIMEOUT)
    begin
      @(posedge clk);
      cyc++;
    end
    if (!rst_n)
    begin
      $display("Timeout: reset still active after %0d cycles", RST_TIMEOUT);
      timeouts++;
    end
    else
    begin
      cyc = 0;
      while (loop_hits < 2 && cyc < RUN_TIMEOUT)  // Final loop retires twice
      begin
        @(negedge clk);
        cyc++;
        if (retire_valid && retire_pc == LOOP_PC)
          loop_hits++;
      end
      if (loop_hits < 2)
      begin
        $display("Timeout: program did not reach its final loop in %0d cycles",
                 RUN_TIMEOUT);
        timeouts++;
      end
    end
    @(negedge clk);
    errors = u_dut.u_chk.err_cnt;
    $display("Assertion errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: list.f
hdl/riscv_isa_pkg.sv
hdl/riscv_pipe_pkg.sv
hdl/riscv_wb_if.sv
hdl/riscv_rf.sv
hdl/riscv_if.sv
hdl/riscv_id.sv
hdl/riscv_ex.sv
hdl/riscv_core.sv
verif/riscv_tb_clk.sv
verif/riscv_core_chk.sv
verif/riscv_core_tb.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - target: rtl
    files:
      - hdl/riscv_isa_pkg.sv
      - hdl/riscv_pipe_pkg.sv
      - hdl/riscv_wb_if.sv
      - hdl/riscv_rf.sv
      - hdl/riscv_if.sv
      - hdl/riscv_id.sv
      - hdl/riscv_ex.sv
      - hdl/riscv_core.sv

  - target: test
    files:
      - verif/riscv_tb_clk.sv
      - verif/riscv_core_chk.sv
      - verif/riscv_core_tb.sv
